// ==== verilog/exe_pkg.sv ====
package exe_pkg;

    localparam int XLEN  = 64;
    localparam int WLEN  = 32;
    localparam int OP_W  = 5;
    localparam int SRC_W = 3;

    // codes 28 to 31 are illegal
    typedef enum logic [OP_W-1:0] {
        OP_NOP    = 5'd0,
        OP_SLL    = 5'd1,
        OP_SRL    = 5'd2,
        OP_SRA    = 5'd3,
        OP_ADD    = 5'd4,
        OP_SUB    = 5'd5,
        OP_XOR    = 5'd6,
        OP_OR     = 5'd7,
        OP_AND    = 5'd8,
        OP_SLT    = 5'd9,
        OP_SLTU   = 5'd10,
        OP_MUL    = 5'd11,
        OP_MULH   = 5'd12,
        OP_MULHSU = 5'd13,
        OP_DIV    = 5'd14,
        OP_DIVU   = 5'd15,
        OP_REM    = 5'd16,
        OP_REMU   = 5'd17,
        OP_SLLW   = 5'd18,
        OP_SRLW   = 5'd19,
        OP_SRAW   = 5'd20,
        OP_ADDW   = 5'd21,
        OP_SUBW   = 5'd22,
        OP_MULW   = 5'd23,
        OP_DIVW   = 5'd24,
        OP_DIVUW  = 5'd25,
        OP_REMW   = 5'd26,
        OP_REMUW  = 5'd27
    } exe_op_e;

    // named after the src1/src2 pair they select
    typedef enum logic [SRC_W-1:0] {
        SRC_NONE   = 3'd0,
        SRC_R_R    = 3'd1,
        SRC_R_I    = 3'd2,
        SRC_PC_I   = 3'd3,
        SRC_R_CSR  = 3'd4,
        SRC_NR_CSR = 3'd5,
        SRC_CSR_Z  = 3'd6,
        SRC_CSR_NZ = 3'd7
    } exe_src_e;

    // rv64 word results are sign-extended from bit 31
    function automatic logic [XLEN-1:0] sext_word(input logic [WLEN-1:0] w);
        return {{(XLEN-WLEN){w[WLEN-1]}}, w};
    endfunction

endpackage

// ==== verilog/exe_operand_if.sv ====
`timescale 1ns/1ns

interface exe_operand_if import exe_pkg::*; ();

    logic            valid;
    exe_op_e         op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;

    modport source (
        output valid,
        output op,
        output src1,
        output src2
    );

    modport sink (
        input valid,
        input op,
        input src1,
        input src2
    );

endinterface

// ==== verilog/exe_operand_mux.sv ====
`timescale 1ns/1ns

module exe_operand_mux import exe_pkg::*; (
    input  logic            in_valid,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] csr_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] zimm,
    input  logic [XLEN-1:0] pc,
    input  exe_op_e         op,
    input  exe_src_e        src,
    exe_operand_if.source   opnd
);

    assign opnd.valid = in_valid;
    assign opnd.op    = op;

    always_comb begin
        opnd.src1 = '0;
        opnd.src2 = '0;
        // idle and nop cycles keep both sources at zero
        if (in_valid && op != OP_NOP) begin
            case (src)
                SRC_R_R: begin
                    opnd.src1 = rs1_data;
                    opnd.src2 = rs2_data;
                end
                SRC_R_I: begin
                    opnd.src1 = rs1_data;
                    opnd.src2 = imm;
                end
                SRC_PC_I: begin
                    opnd.src1 = pc;
                    opnd.src2 = imm;
                end
                SRC_R_CSR: begin
                    opnd.src1 = rs1_data;
                    opnd.src2 = csr_data;
                end
                // csrrc ands the csr with the inverted mask
                SRC_NR_CSR: begin
                    opnd.src1 = ~rs1_data;
                    opnd.src2 = csr_data;
                end
                SRC_CSR_Z: begin
                    opnd.src1 = csr_data;
                    opnd.src2 = zimm;
                end
                // csrrci
                SRC_CSR_NZ: begin
                    opnd.src1 = csr_data;
                    opnd.src2 = ~zimm;
                end
                default: begin
                    opnd.src1 = '0;
                    opnd.src2 = '0;
                end
            endcase
        end
    end

endmodule

// ==== verilog/exe_alu.sv ====
`timescale 1ns/1ns

module exe_alu import exe_pkg::*; (
    exe_operand_if.sink     opnd,
    output logic [XLEN-1:0] alu_result,
    output logic            alu_hit
);

    logic [XLEN-1:0]          src1;
    logic [XLEN-1:0]          src2;
    logic [$clog2(XLEN)-1:0]  shamt;
    logic [$clog2(WLEN)-1:0]  shamt_w;
    logic [WLEN-1:0]          sll_w;
    logic [WLEN-1:0]          srl_w;
    logic [WLEN-1:0]          sra_w;
    logic [WLEN-1:0]          add_w;
    logic [WLEN-1:0]          sub_w;
    logic                     owned;

    assign src1    = opnd.src1;
    assign src2    = opnd.src2;
    assign shamt   = src2[$clog2(XLEN)-1:0];
    assign shamt_w = src2[$clog2(WLEN)-1:0];

    // word forms only look at the low half of src1
    assign sll_w = src1[WLEN-1:0] << shamt_w;
    assign srl_w = src1[WLEN-1:0] >> shamt_w;
    assign sra_w = $signed(src1[WLEN-1:0]) >>> shamt_w;
    assign add_w = src1[WLEN-1:0] + src2[WLEN-1:0];
    assign sub_w = src1[WLEN-1:0] - src2[WLEN-1:0];

    always_comb begin
        owned      = 1'b1;
        alu_result = '0;
        case (opnd.op)
            OP_SLL:  alu_result = src1 << shamt;
            OP_SRL:  alu_result = src1 >> shamt;
            OP_SRA:  alu_result = $signed(src1) >>> shamt;
            OP_ADD:  alu_result = src1 + src2;
            OP_SUB:  alu_result = src1 - src2;
            OP_XOR:  alu_result = src1 ^ src2;
            OP_OR:   alu_result = src1 | src2;
            OP_AND:  alu_result = src1 & src2;
            OP_SLT:  alu_result = XLEN'($signed(src1) < $signed(src2));
            OP_SLTU: alu_result = XLEN'(src1 < src2);
            OP_SLLW: alu_result = sext_word(sll_w);
            OP_SRLW: alu_result = sext_word(srl_w);
            OP_SRAW: alu_result = sext_word(sra_w);
            OP_ADDW: alu_result = sext_word(add_w);
            OP_SUBW: alu_result = sext_word(sub_w);
            default: owned = 1'b0;
        endcase
    end

    assign alu_hit = opnd.valid & owned;

endmodule

// ==== verilog/exe_muldiv.sv ====
`timescale 1ns/1ns

module exe_muldiv import exe_pkg::*; (
    exe_operand_if.sink     opnd,
    output logic [XLEN-1:0] md_result,
    output logic            md_hit
);

    logic [XLEN-1:0]          src1;
    logic [XLEN-1:0]          src2;
    logic signed [2*XLEN-1:0] prod_ss;
    logic signed [2*XLEN-1:0] prod_su;
    logic [WLEN-1:0]          prod_w;
    logic                     div_zero;
    logic                     div_ovf;
    logic [XLEN-1:0]          divisor_s;
    logic [XLEN-1:0]          divisor_u;
    logic signed [XLEN-1:0]   quot_s;
    logic signed [XLEN-1:0]   rem_s;
    logic [XLEN-1:0]          quot_u;
    logic [XLEN-1:0]          rem_u;
    logic [WLEN-1:0]          a_w;
    logic [WLEN-1:0]          b_w;
    logic                     div_zero_w;
    logic                     div_ovf_w;
    logic [WLEN-1:0]          divisor_sw;
    logic [WLEN-1:0]          divisor_uw;
    logic signed [WLEN-1:0]   quot_sw;
    logic signed [WLEN-1:0]   rem_sw;
    logic [WLEN-1:0]          quot_uw;
    logic [WLEN-1:0]          rem_uw;
    logic                     owned;

    assign src1 = opnd.src1;
    assign src2 = opnd.src2;
    assign a_w  = src1[WLEN-1:0];
    assign b_w  = src2[WLEN-1:0];

    assign prod_ss = $signed(src1) * $signed(src2);
    // zero-extend src2 so it multiplies as unsigned
    assign prod_su = $signed(src1) * $signed({1'b0, src2});
    assign prod_w  = a_w * b_w;

    assign div_zero   = (src2 == '0);
    assign div_ovf    = (src1 == {1'b1, {(XLEN-1){1'b0}}}) && (src2 == '1);
    assign div_zero_w = (b_w == '0);
    assign div_ovf_w  = (a_w == {1'b1, {(WLEN-1){1'b0}}}) && (b_w == '1);

    // special divisors are swapped for 1 and their results come from the rules below
    assign divisor_s  = (div_zero || div_ovf) ? XLEN'(1) : src2;
    assign divisor_u  = div_zero ? XLEN'(1) : src2;
    assign divisor_sw = (div_zero_w || div_ovf_w) ? WLEN'(1) : b_w;
    assign divisor_uw = div_zero_w ? WLEN'(1) : b_w;

    assign quot_s  = $signed(src1) / $signed(divisor_s);
    assign rem_s   = $signed(src1) % $signed(divisor_s);
    assign quot_u  = src1 / divisor_u;
    assign rem_u   = src1 % divisor_u;
    assign quot_sw = $signed(a_w) / $signed(divisor_sw);
    assign rem_sw  = $signed(a_w) % $signed(divisor_sw);
    assign quot_uw = a_w / divisor_uw;
    assign rem_uw  = a_w % divisor_uw;

    always_comb begin
        owned     = 1'b1;
        md_result = '0;
        case (opnd.op)
            OP_MUL:    md_result = prod_ss[XLEN-1:0];
            OP_MULH:   md_result = prod_ss[2*XLEN-1:XLEN];
            OP_MULHSU: md_result = prod_su[2*XLEN-1:XLEN];
            OP_DIV:    md_result = div_zero ? '1 : (div_ovf ? src1 : quot_s);
            OP_DIVU:   md_result = div_zero ? '1 : quot_u;
            OP_REM:    md_result = div_zero ? src1 : (div_ovf ? '0 : rem_s);
            OP_REMU:   md_result = div_zero ? src1 : rem_u;
            OP_MULW:   md_result = sext_word(prod_w);
            OP_DIVW:   md_result = sext_word(div_zero_w ? '1 : (div_ovf_w ? a_w : quot_sw));
            OP_DIVUW:  md_result = sext_word(div_zero_w ? '1 : quot_uw);
            OP_REMW:   md_result = sext_word(div_zero_w ? a_w : (div_ovf_w ? '0 : rem_sw));
            OP_REMUW:  md_result = sext_word(div_zero_w ? a_w : rem_uw);
            default:   owned = 1'b0;
        endcase
    end

    assign md_hit = opnd.valid & owned;

endmodule

// ==== verilog/exe_result_stage.sv ====
`timescale 1ns/1ns

module exe_result_stage import exe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            valid,
    input  exe_op_e         op,
    input  logic [XLEN-1:0] alu_result,
    input  logic            alu_hit,
    input  logic [XLEN-1:0] md_result,
    input  logic            md_hit,
    output logic [XLEN-1:0] result,
    output logic            out_valid,
    output logic            illegal_op
);

    logic [XLEN-1:0] result_d;
    logic            illegal_d;

    // at most one unit owns an op
    assign result_d = alu_hit ? alu_result : (md_hit ? md_result : '0);

    // no unit claimed it and it is not a nop
    assign illegal_d = valid && !alu_hit && !md_hit && (op != OP_NOP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result     <= '0;
            out_valid  <= 1'b0;
            illegal_op <= 1'b0;
        end else begin
            result     <= result_d;
            out_valid  <= valid;
            illegal_op <= illegal_d;
        end
    end

endmodule

// ==== verilog/exe_top.sv ====
`timescale 1ns/1ns

module exe_top import exe_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] csr_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] zimm,
    input  logic [XLEN-1:0] pc,
    input  exe_op_e         op,
    input  exe_src_e        src,
    output logic [XLEN-1:0] result,
    output logic            out_valid,
    output logic            illegal_op
);

    logic [XLEN-1:0] alu_result;
    logic            alu_hit;
    logic [XLEN-1:0] md_result;
    logic            md_hit;

    exe_operand_if u_opnd_if ();

    exe_operand_mux u_operand_mux (
        .in_valid (in_valid),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .csr_data (csr_data),
        .imm      (imm),
        .zimm     (zimm),
        .pc       (pc),
        .op       (op),
        .src      (src),
        .opnd     (u_opnd_if.source)
    );

    exe_alu u_alu (
        .opnd       (u_opnd_if.sink),
        .alu_result (alu_result),
        .alu_hit    (alu_hit)
    );

    exe_muldiv u_muldiv (
        .opnd      (u_opnd_if.sink),
        .md_result (md_result),
        .md_hit    (md_hit)
    );

    exe_result_stage u_result_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid      (in_valid),
        .op         (op),
        .alu_result (alu_result),
        .alu_hit    (alu_hit),
        .md_result  (md_result),
        .md_hit     (md_hit),
        .result     (result),
        .out_valid  (out_valid),
        .illegal_op (illegal_op)
    );

endmodule

// ==== verification/exe_checker.sv ====
`timescale 1ns/1ns

module exe_checker import exe_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic [XLEN-1:0] result,
    input logic            out_valid,
    input logic            illegal_op
);

    // an empty slot carries nothing
    a_idle_clear: assert property (@(posedge clk) disable iff (!arst_n)
        !out_valid |-> (result == '0 && !illegal_op))
        else $error("out_valid low with a nonzero result or illegal_op set");

    a_illegal_zero: assert property (@(posedge clk) disable iff (!arst_n)
        illegal_op |-> result == '0)
        else $error("illegal_op set with a nonzero result");

    a_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({result, out_valid, illegal_op}))
        else $error("unknown value on the stage outputs");

endmodule

bind exe_top exe_checker u_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .result     (result),
    .out_valid  (out_valid),
    .illegal_op (illegal_op)
);

// ==== verification/exe_tb.sv ====
`timescale 1ns/1ns

module exe_tb import exe_pkg::*; ();

    localparam int N_RANDOM   = 4000;
    localparam int N_DIRECTED = 16 + 8 * 3 * 4 + 17 * 25;
    localparam int TIMEOUT_NS = (N_RANDOM + N_DIRECTED + 8 + 100) * 4;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] csr_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] zimm;
    logic [XLEN-1:0] pc;
    exe_op_e         op;
    exe_src_e        src;
    logic [XLEN-1:0] result;
    logic            out_valid;
    logic            illegal_op;

    logic [31:0]     lfsr;
    logic [XLEN-1:0] exp_result;
    logic            exp_valid;
    logic            exp_illegal;
    exe_op_e         logic_ops [3] = '{OP_ADD, OP_OR, OP_AND};

    exe_top u_exe_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns before the test finished", TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "simulation timed out");
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] corner(input int idx);
        case (idx)
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, 63'b0};
            3:       return 64'd1;
            // most negative word sign-extended to 64 bits
            default: return 64'hffff_ffff_8000_0000;
        endcase
    endfunction

    function automatic logic [63:0] pick_operand();
        // about one draw in four is a corner value
        if (lfsr_bits(2) == 0)
            return corner(int'(lfsr_bits(2)));
        return lfsr_bits(64);
    endfunction

    // operands arrive already extended to 64 bits
    function automatic logic [63:0] divide(input logic [63:0] a, input logic [63:0] b,
                                           input logic sgn, input logic rem);
        if (b == '0)
            return rem ? a : '1;
        if (sgn && a == {1'b1, 63'b0} && b == '1)
            return rem ? '0 : a;
        if (sgn && rem)
            return $signed(a) % $signed(b);
        if (sgn)
            return $signed(a) / $signed(b);
        return rem ? a % b : a / b;
    endfunction

    function automatic logic [63:0] model_result(input exe_op_e code, input logic [63:0] a,
                                                 input logic [63:0] b);
        logic [63:0] r;
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] za;
        logic [63:0] zb;
        sa = {{32{a[31]}}, a[31:0]};
        sb = {{32{b[31]}}, b[31:0]};
        za = {32'b0, a[31:0]};
        zb = {32'b0, b[31:0]};
        case (code)
            OP_SLL:             r = a << b[5:0];
            OP_SRL:             r = a >> b[5:0];
            OP_SRA:             r = $signed(a) >>> b[5:0];
            OP_ADD, OP_ADDW:    r = a + b;
            OP_SUB, OP_SUBW:    r = a - b;
            OP_XOR:             r = a ^ b;
            OP_OR:              r = a | b;
            OP_AND:             r = a & b;
            OP_SLT:             r = {63'b0, $signed(a) < $signed(b)};
            OP_SLTU:            r = {63'b0, a < b};
            OP_MUL, OP_MULW:    r = a * b;
            OP_MULH:            r = 64'(({{64{a[63]}}, a} * {{64{b[63]}}, b}) >> 64);
            OP_MULHSU:          r = 64'(({{64{a[63]}}, a} * {64'b0, b}) >> 64);
            OP_DIV, OP_REM:     r = divide(a, b, 1'b1, code == OP_REM);
            OP_DIVU, OP_REMU:   r = divide(a, b, 1'b0, code == OP_REMU);
            OP_SLLW:            r = a << b[4:0];
            OP_SRLW:            r = za >> b[4:0];
            OP_SRAW:            r = $signed(sa) >>> b[4:0];
            OP_DIVW, OP_REMW:   r = divide(sa, sb, 1'b1, code == OP_REMW);
            OP_DIVUW, OP_REMUW: r = divide(za, zb, 1'b0, code == OP_REMUW);
            default:            r = '0;
        endcase
        // word forms keep the low word sign-extended
        if (code >= OP_SLLW)
            r = {{32{r[31]}}, r[31:0]};
        return r;
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "output compare failed");
        end
    endtask

    // checks the previous op and then puts random values on every input
    task automatic next_cycle();
        @(negedge clk);
        check_value("result", result, exp_result);
        check_value("out_valid", 64'(out_valid), 64'(exp_valid));
        check_value("illegal_op", 64'(illegal_op), 64'(exp_illegal));
        in_valid = lfsr_bits(3) != 0;
        op       = exe_op_e'(5'(lfsr_bits(5)));
        src      = exe_src_e'(3'(lfsr_bits(3)));
        rs1_data = pick_operand();
        rs2_data = pick_operand();
        csr_data = pick_operand();
        imm      = pick_operand();
        zimm     = pick_operand();
        pc       = pick_operand();
    endtask

    task automatic predict();
        logic [63:0] s1;
        logic [63:0] s2;
        s1 = '0;
        s2 = '0;
        // both sources stay zero for idle or nop
        if (in_valid && op != OP_NOP) begin
            case (src)
                SRC_R_R, SRC_R_I, SRC_R_CSR: s1 = rs1_data;
                SRC_PC_I:                    s1 = pc;
                SRC_NR_CSR:                  s1 = ~rs1_data;
                SRC_CSR_Z, SRC_CSR_NZ:       s1 = csr_data;
                default:                     s1 = '0;
            endcase
            case (src)
                SRC_R_R:               s2 = rs2_data;
                SRC_R_I, SRC_PC_I:     s2 = imm;
                SRC_R_CSR, SRC_NR_CSR: s2 = csr_data;
                SRC_CSR_Z:             s2 = zimm;
                SRC_CSR_NZ:            s2 = ~zimm;
                default:               s2 = '0;
            endcase
        end
        exp_valid   = in_valid;
        exp_illegal = in_valid && op > OP_REMUW;
        exp_result  = in_valid ? model_result(op, s1, s2) : '0;
    endtask

    initial begin
        lfsr     = 32'h79d2;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        op       = OP_NOP;
        src      = SRC_NONE;
        {rs1_data, rs2_data, csr_data, imm, zimm, pc} = '0;
        {exp_valid, exp_illegal, exp_result} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // idle slots
        repeat (16) begin
            next_cycle();
            in_valid = 1'b0;
            predict();
        end
        // every source pair through add, or, and
        for (int s = 0; s < 8; s++) begin
            foreach (logic_ops[k]) begin
                repeat (4) begin
                    next_cycle();
                    in_valid = 1'b1;
                    op       = logic_ops[k];
                    src      = exe_src_e'(s);
                    predict();
                end
            end
        end
        // corner pairs including zero divisors and overflow
        for (int c = OP_MUL; c <= OP_REMUW; c++) begin
            for (int i = 0; i < 25; i++) begin
                next_cycle();
                in_valid = 1'b1;
                op       = exe_op_e'(c);
                src      = SRC_R_R;
                rs1_data = corner(i / 5);
                rs2_data = corner(i % 5);
                predict();
            end
        end
        repeat (N_RANDOM) begin
            next_cycle();
            predict();
        end
        next_cycle();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== exe.f ====
verilog/exe_pkg.sv
verilog/exe_operand_if.sv
verilog/exe_operand_mux.sv
verilog/exe_alu.sv
verilog/exe_muldiv.sv
verilog/exe_result_stage.sv
verilog/exe_top.sv
verification/exe_checker.sv
verification/exe_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
set -e
set -o pipefail

verilator --binary --assert -Wno-fatal --top-module exe_tb -f exe.f
./obj_dir/Vexe_tb 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
